/* sim.f */
src/tlb_pkg.sv
src/tlb_csr_pkg.sv
src/tlb_mgmt_wb.sv
src/tlb_slot.sv
src/tlb_hit_select.sv
src/tlb_top.sv
verif/tlb_chk.sv
verif/tlb_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tlb_tb
FILELIST  = sim.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^All tests passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* verif/tlb_tb.sv */
`timescale 1ns/10ps

module tlb_tb
    import tlb_pkg::*, tlb_csr_pkg::*;
();

    localparam int ENTRIES     = 16;
    localparam int ACK_TIMEOUT = 20;

    localparam logic [2:0] K_WRITE    = 3'd0;
    localparam logic [2:0] K_INV      = 3'd1;
    localparam logic [2:0] K_LOOKUP   = 3'd2;
    localparam logic [2:0] K_READ     = 3'd3;
    localparam logic [2:0] K_READ_ALL = 3'd4;
    localparam logic [2:0] K_RANDOM   = 3'd5;

    // one table row, unused fields stay zero
    typedef struct packed {
        logic [2:0]  kind;
        int          idx;
        logic [2:0]  flags;
        logic [9:0]  asid;
        logic [18:0] vppn;
        logic [4:0]  op;
        logic        port;
        logic        bit12;
    } step_t;

    logic        clk;
    logic        resetn;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [2:0]  adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        ack;
    vppn_u       s0_vppn;
    logic        s0_va_bit12;
    logic [9:0]  s0_asid;
    tlb_result_t s0_result;
    vppn_u       s1_vppn;
    logic        s1_va_bit12;
    logic [9:0]  s1_asid;
    tlb_result_t s1_result;

    tlb_entry_t  model [ENTRIES];
    step_t       steps [$];
    logic [31:0] lcg_state;

    tlb_top #(
        .ENTRIES (ENTRIES)
    ) dut (
        .clk         (clk),
        .resetn      (resetn),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .adr         (adr),
        .dat_w       (dat_w),
        .dat_r       (dat_r),
        .ack         (ack),
        .s0_vppn     (s0_vppn),
        .s0_va_bit12 (s0_va_bit12),
        .s0_asid     (s0_asid),
        .s0_result   (s0_result),
        .s1_vppn     (s1_vppn),
        .s1_va_bit12 (s1_va_bit12),
        .s1_asid     (s1_asid),
        .s1_result   (s1_result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_result(input tlb_result_t got, input tlb_result_t exp,
                                input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: %s gave %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_entry(input tlb_entry_t got, input tlb_entry_t exp, input int idx);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: entry %0d read back as %h, expected %h",
                                $time, idx, got, exp));
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // 4 MB pages only look at vppn[18:10]
    function automatic logic page_match(input tlb_entry_t ent, input logic [18:0] vppn);
        if (ent.ps4mb) begin
            return ent.vppn.full[18:10] == vppn[18:10];
        end
        return ent.vppn.full == vppn;
    endfunction

    function automatic logic inv_applies(input tlb_entry_t ent, input logic [4:0] op,
                                         input logic [9:0] asid, input logic [18:0] vppn);
        logic same_asid;
        logic same_va;
        same_asid = ent.asid == asid;
        same_va = page_match(ent, vppn);
        case (op)
            INV_ALL0, INV_ALL1: return 1'b1;
            INV_G1:             return ent.g;
            INV_G0:             return !ent.g;
            INV_G0_ASID:        return !ent.g && same_asid;
            INV_G0_ASID_VPN:    return !ent.g && same_asid && same_va;
            INV_G1_ASID_VPN:    return ent.g && same_asid && same_va;
            default:            return 1'b0;
        endcase
    endfunction

    function automatic tlb_result_t expect_lookup(input logic [18:0] vppn, input logic bit12,
                                                  input logic [9:0] asid);
        tlb_result_t r;
        logic        odd;
        int          i;
        r = '0;
        for (i = 0; i < ENTRIES; i++) begin
            if (!r.found && model[i].e && page_match(model[i], vppn) &&
                (model[i].g || model[i].asid == asid)) begin
                odd = model[i].ps4mb ? vppn[9] : bit12;
                r.found = 1'b1;
                r.index = 8'(i);
                r.ps = model[i].ps4mb ? 6'd22 : 6'd12;
                r.page = odd ? model[i].page1 : model[i].page0;
            end
        end
        return r;
    endfunction

    // pages differ per slot and per half so a wrong pick shows up
    function automatic tlb_entry_t make_entry(input int idx, input logic [2:0] flags,
                                              input logic [9:0] asid, input logic [18:0] vppn);
        tlb_entry_t ent;
        ent = '0;
        ent.e = flags[2];
        ent.ps4mb = flags[1];
        ent.g = flags[0];
        ent.asid = asid;
        ent.vppn.full = vppn;
        ent.page0.ppn = 20'h40000 + 20'(idx * 2);
        ent.page0.plv = 2'(idx);
        ent.page0.mat = 2'd1;
        ent.page0.v = 1'b1;
        ent.page1.ppn = 20'h40001 + 20'(idx * 2);
        ent.page1.plv = 2'(idx + 1);
        ent.page1.mat = 2'd2;
        ent.page1.d = 1'b1;
        ent.page1.v = 1'b1;
        return ent;
    endfunction

    function automatic logic [31:0] hi_word(input tlb_entry_t ent);
        logic [31:0] w;
        w = '0;
        w[HI_VPPN_LSB +: 19] = ent.vppn.full;
        w[0] = ent.e;
        w[1] = ent.ps4mb;
        w[2] = ent.g;
        return w;
    endfunction

    function automatic logic [31:0] page_to_word(input tlb_page_t p);
        logic [31:0] w;
        w = '0;
        w[0] = p.v;
        w[1] = p.d;
        w[3:2] = p.plv;
        w[5:4] = p.mat;
        w[LO_PPN_LSB +: 20] = p.ppn;
        return w;
    endfunction

    function automatic tlb_page_t word_to_page(input logic [31:0] w);
        tlb_page_t p;
        p.v = w[0];
        p.d = w[1];
        p.plv = w[3:2];
        p.mat = w[5:4];
        p.ppn = w[LO_PPN_LSB +: 20];
        return p;
    endfunction

    task automatic wait_ack();
        int n;
        n = 0;
        while (!ack && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!ack) begin
            abort_run("Error: the Wishbone bus did not acknowledge within 20 cycles");
        end
    endtask

    task automatic wb_write(input logic [2:0] a, input logic [31:0] d);
        @(posedge clk);
        #1;
        cyc = 1'b1;
        stb = 1'b1;
        we = 1'b1;
        adr = a;
        dat_w = d;
        wait_ack();
        @(posedge clk);
        #1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
    endtask

    task automatic wb_read(input logic [2:0] a, output logic [31:0] d);
        @(posedge clk);
        #1;
        cyc = 1'b1;
        stb = 1'b1;
        we = 1'b0;
        adr = a;
        wait_ack();
        d = dat_r;
        @(posedge clk);
        #1;
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    task automatic write_entry(input step_t s);
        tlb_entry_t ent;
        ent = make_entry(s.idx, s.flags, s.asid, s.vppn);
        wb_write(REG_HI, hi_word(ent));
        wb_write(REG_ASID, 32'(ent.asid));
        wb_write(REG_LO0, page_to_word(ent.page0));
        wb_write(REG_LO1, page_to_word(ent.page1));
        wb_write(REG_INDEX, 32'(s.idx));
        wb_write(REG_CMD, 32'(CMD_WRITE));
        model[s.idx] = ent;
    endtask

    task automatic apply_invalidate(input step_t s);
        int i;
        wb_write(REG_ASID, 32'(s.asid));
        wb_write(REG_HI, 32'(s.vppn) << HI_VPPN_LSB);
        wb_write(REG_CMD, (32'(s.op) << CMD_INV_OP_LSB) | 32'(CMD_INV));
        // disabled entries are left as they are
        for (i = 0; i < ENTRIES; i++) begin
            if (model[i].e && inv_applies(model[i], s.op, s.asid, s.vppn)) begin
                model[i] = '0;
            end
        end
    endtask

    // both ports are checked every time, the other one keeps its last address
    task automatic drive_lookup(input logic port, input logic [18:0] vppn, input logic bit12,
                                input logic [9:0] asid);
        @(posedge clk);
        #1;
        if (port) begin
            s1_vppn.full = vppn;
            s1_va_bit12 = bit12;
            s1_asid = asid;
        end else begin
            s0_vppn.full = vppn;
            s0_va_bit12 = bit12;
            s0_asid = asid;
        end
        @(negedge clk);
        check_result(s0_result, expect_lookup(s0_vppn.full, s0_va_bit12, s0_asid),
                     "port 0 lookup");
        check_result(s1_result, expect_lookup(s1_vppn.full, s1_va_bit12, s1_asid),
                     "port 1 lookup");
    endtask

    task automatic check_readback(input int idx);
        tlb_entry_t  got;
        logic [31:0] w;
        got = '0;
        wb_write(REG_INDEX, 32'(idx));
        wb_write(REG_CMD, 32'(CMD_READ));
        wb_read(REG_HI, w);
        got.vppn.full = w[HI_VPPN_LSB +: 19];
        got.e = w[0];
        got.ps4mb = w[1];
        got.g = w[2];
        wb_read(REG_ASID, w);
        got.asid = w[9:0];
        wb_read(REG_LO0, w);
        got.page0 = word_to_page(w);
        wb_read(REG_LO1, w);
        got.page1 = word_to_page(w);
        check_entry(got, model[idx], idx);
    endtask

    task automatic add_step(input logic [2:0] kind, input int idx, input logic [2:0] flags,
                            input logic [9:0] asid, input logic [18:0] vppn,
                            input logic [4:0] op, input logic port, input logic bit12);
        step_t s;
        s.kind = kind;
        s.idx = idx;
        s.flags = flags;
        s.asid = asid;
        s.vppn = vppn;
        s.op = op;
        s.port = port;
        s.bit12 = bit12;
        steps.push_back(s);
    endtask

    // flags are {e, ps4mb, g}; port and va bit 12 come last
    task automatic build_table();
        add_step(K_RANDOM, 0, 3'b000, 10'h000, 19'h00000, 5'd0, 1'b0, 1'b0);
        add_step(K_RANDOM, 0, 3'b000, 10'h000, 19'h00000, 5'd0, 1'b1, 1'b0);
        add_step(K_READ_ALL, 0, 3'b000, 10'h000, 19'h00000, 5'd0, 1'b0, 1'b0);
        add_step(K_WRITE, 2, 3'b100, 10'h005, 19'h12345, 5'd0, 1'b0, 1'b0);
        add_step(K_WRITE, 5, 3'b110, 10'h005, 19'h2a000, 5'd0, 1'b0, 1'b0);
        add_step(K_WRITE, 9, 3'b101, 10'h3ff, 19'h00777, 5'd0, 1'b0, 1'b0);
        add_step(K_WRITE, 11, 3'b000, 10'h005, 19'h11111, 5'd0, 1'b0, 1'b0);
        add_step(K_WRITE, 12, 3'b100, 10'h005, 19'h12345, 5'd0, 1'b0, 1'b0);
        add_step(K_WRITE, 14, 3'b111, 10'h000, 19'h55400, 5'd0, 1'b0, 1'b0);
        // slot 2 and 12 overlap, vppn bit 9 picks the half of a 4 MB pair
        add_step(K_LOOKUP, 0, 3'b000, 10'h005, 19'h12345, 5'd0, 1'b0, 1'b0);
        add_step(K_LOOKUP, 0, 3'b000, 10'h005, 19'h12345, 5'd0, 1'b1, 1'b1);
        add_step(K_LOOKUP, 0, 3'b000, 10'h005, 19'h2a000, 5'd0, 1'b0, 1'b1);
        add_step(K_LOOKUP, 0, 3'b000, 10'h005, 19'h2a3ff, 5'd0, 1'b1, 1'b0);
        add_step(K_LOOKUP, 0, 3'b000, 10'h005, 19'h2a400, 5'd0, 1'b0, 1'b0);
        add_step(K_LOOKUP, 0, 3'b000, 10'h001, 19'h00777, 5'd0, 1'b1, 1'b1);
        add_step(K_LOOKUP, 0, 3'b000, 10'h006, 19'h12345, 5'd0, 1'b0, 1'b0);
        add_step(K_LOOKUP, 0, 3'b000, 10'h005, 19'h11111, 5'd0, 1'b1, 1'b0);
        add_step(K_LOOKUP, 0, 3'b000, 10'h2aa, 19'h557ff, 5'd0, 1'b0, 1'b1);
        add_step(K_READ, 2, 3'b000, 10'h000, 19'h00000, 5'd0, 1'b0, 1'b0);
        add_step(K_READ, 5, 3'b000, 10'h000, 19'h00000, 5'd0, 1'b0, 1'b0);
        add_step(K_READ, 11, 3'b000, 10'h000, 19'h00000, 5'd0, 1'b0, 1'b0);
        add_step(K_READ, 14, 3'b000, 10'h000, 19'h00000, 5'd0, 1'b0, 1'b0);
        add_step(K_INV, 0, 3'b000, 10'h005, 19'h12345, 5'd7, 1'b0, 1'b0);
        add_step(K_READ_ALL, 0, 3'b000, 10'h000, 19'h00000, 5'd0, 1'b0, 1'b0);
        add_step(K_INV, 0, 3'b000, 10'h005, 19'h12345, 5'd5, 1'b0, 1'b0);
        add_step(K_LOOKUP, 0, 3'b000, 10'h005, 19'h12345, 5'd0, 1'b0, 1'b0);
        add_step(K_READ_ALL, 0, 3'b000, 10'h000, 19'h00000, 5'd0, 1'b0, 1'b0);
        add_step(K_INV, 0, 3'b000, 10'h3ff, 19'h00777, 5'd6, 1'b0, 1'b0);
        add_step(K_LOOKUP, 0, 3'b000, 10'h001, 19'h00777, 5'd0, 1'b1, 1'b0);
        add_step(K_INV, 0, 3'b000, 10'h005, 19'h00000, 5'd4, 1'b0, 1'b0);
        add_step(K_READ_ALL, 0, 3'b000, 10'h000, 19'h00000, 5'd0, 1'b0, 1'b0);
        add_step(K_WRITE, 3, 3'b100, 10'h007, 19'h01234, 5'd0, 1'b0, 1'b0);
        add_step(K_WRITE, 4, 3'b101, 10'h008, 19'h04321, 5'd0, 1'b0, 1'b0);
        add_step(K_INV, 0, 3'b000, 10'h000, 19'h553ff, 5'd6, 1'b0, 1'b0);
        add_step(K_INV, 0, 3'b000, 10'h000, 19'h00000, 5'd3, 1'b0, 1'b0);
        add_step(K_READ_ALL, 0, 3'b000, 10'h000, 19'h00000, 5'd0, 1'b0, 1'b0);
        add_step(K_INV, 0, 3'b000, 10'h000, 19'h00000, 5'd2, 1'b0, 1'b0);
        add_step(K_READ_ALL, 0, 3'b000, 10'h000, 19'h00000, 5'd0, 1'b0, 1'b0);
        add_step(K_WRITE, 0, 3'b100, 10'h001, 19'h7ffff, 5'd0, 1'b0, 1'b0);
        add_step(K_WRITE, 1, 3'b110, 10'h002, 19'h7fc00, 5'd0, 1'b0, 1'b0);
        add_step(K_LOOKUP, 0, 3'b000, 10'h002, 19'h7fc00, 5'd0, 1'b0, 1'b1);
        add_step(K_LOOKUP, 0, 3'b000, 10'h001, 19'h7ffff, 5'd0, 1'b1, 1'b1);
        add_step(K_INV, 0, 3'b000, 10'h000, 19'h00000, 5'd0, 1'b0, 1'b0);
        add_step(K_READ_ALL, 0, 3'b000, 10'h000, 19'h00000, 5'd0, 1'b0, 1'b0);
        add_step(K_WRITE, 6, 3'b101, 10'h0aa, 19'h0c0c0, 5'd0, 1'b0, 1'b0);
        add_step(K_INV, 0, 3'b000, 10'h000, 19'h00000, 5'd1, 1'b0, 1'b0);
        add_step(K_READ_ALL, 0, 3'b000, 10'h000, 19'h00000, 5'd0, 1'b0, 1'b0);
        add_step(K_RANDOM, 0, 3'b000, 10'h000, 19'h00000, 5'd0, 1'b0, 1'b0);
        add_step(K_RANDOM, 0, 3'b000, 10'h000, 19'h00000, 5'd0, 1'b1, 1'b0);
    endtask

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        int          k;
        int          i;
        resetn = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        s0_vppn = '0;
        s0_va_bit12 = 1'b0;
        s0_asid = '0;
        s1_vppn = '0;
        s1_va_bit12 = 1'b0;
        s1_asid = '0;
        lcg_state = 32'd1;
        for (i = 0; i < ENTRIES; i++) begin
            model[i] = '0;
        end
        build_table();
        repeat (3) @(posedge clk);
        #1;
        resetn = 1'b0;
        for (k = 0; k < steps.size(); k++) begin
            case (steps[k].kind)
                K_WRITE:  write_entry(steps[k]);
                K_INV:    apply_invalidate(steps[k]);
                K_LOOKUP: drive_lookup(steps[k].port, steps[k].vppn, steps[k].bit12,
                                       steps[k].asid);
                K_READ:   check_readback(steps[k].idx);
                K_READ_ALL: begin
                    for (i = 0; i < ENTRIES; i++) begin
                        check_readback(i);
                    end
                end
                default: begin
                    r1 = lcg_next();
                    r2 = lcg_next();
                    drive_lookup(steps[k].port, r1[30:12], r1[31], r2[25:16]);
                end
            endcase
        end
        $display("All tests passed");
        $finish;
    end

endmodule

/* verif/tlb_chk.sv */
`timescale 1ns/10ps

module tlb_chk
    import tlb_pkg::*;
#(
    parameter int ENTRIES = 16
) (
    input logic        clk,
    input logic        resetn,
    input logic        ack,
    input tlb_result_t s0_result,
    input tlb_result_t s1_result
);

    // ack is a one-cycle pulse
    ack_single: assert property (@(posedge clk) disable iff (resetn) ack |=> !ack)
        else $error("ack stayed high for two cycles");

    ack_reset: assert property (@(posedge clk) resetn |=> !ack)
        else $error("ack high while in reset");

    s0_index_range: assert property (@(posedge clk) disable iff (resetn)
                                     s0_result.found |-> int'(s0_result.index) < ENTRIES)
        else $error("port 0 hit index out of range");

    s1_index_range: assert property (@(posedge clk) disable iff (resetn)
                                     s1_result.found |-> int'(s1_result.index) < ENTRIES)
        else $error("port 1 hit index out of range");

endmodule

bind tlb_top tlb_chk #(
    .ENTRIES (ENTRIES)
) u_chk (
    .clk       (clk),
    .resetn    (resetn),
    .ack       (ack),
    .s0_result (s0_result),
    .s1_result (s1_result)
);

/* src/tlb_top.sv */
`timescale 1ns/10ps

module tlb_top
    import tlb_pkg::*;
#(
    parameter int ENTRIES = 16
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [2:0]  adr,
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    output logic        ack,
    // fetch port
    input  vppn_u       s0_vppn,
    input  logic        s0_va_bit12,
    input  logic [9:0]  s0_asid,
    output tlb_result_t s0_result,
    // load/store port
    input  vppn_u       s1_vppn,
    input  logic        s1_va_bit12,
    input  logic [9:0]  s1_asid,
    output tlb_result_t s1_result
);

    localparam int IDX_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

    tlb_entry_t         slot_entries [ENTRIES];
    logic [ENTRIES-1:0] hit0_vec;
    logic [ENTRIES-1:0] hit1_vec;
    logic               wr_valid;
    logic [IDX_W-1:0]   wr_index;
    tlb_entry_t         wr_entry;
    logic               inv_valid;
    logic [4:0]         inv_op;
    logic [9:0]         inv_asid;
    vppn_u              inv_vppn;

    tlb_mgmt_wb #(
        .ENTRIES (ENTRIES)
    ) u_mgmt (
        .clk          (clk),
        .resetn       (resetn),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .dat_w        (dat_w),
        .slot_entries (slot_entries),
        .dat_r        (dat_r),
        .ack          (ack),
        .wr_valid     (wr_valid),
        .wr_index     (wr_index),
        .wr_entry     (wr_entry),
        .inv_valid    (inv_valid),
        .inv_op       (inv_op),
        .inv_asid     (inv_asid),
        .inv_vppn     (inv_vppn)
    );

    for (genvar g = 0; g < ENTRIES; g++) begin : gen_slot
        tlb_slot #(
            .ENTRIES (ENTRIES),
            .SLOT_ID (g)
        ) u_slot (
            .clk       (clk),
            .resetn    (resetn),
            .wr_valid  (wr_valid),
            .wr_index  (wr_index),
            .wr_entry  (wr_entry),
            .inv_valid (inv_valid),
            .inv_op    (inv_op),
            .inv_asid  (inv_asid),
            .inv_vppn  (inv_vppn),
            .s0_vppn   (s0_vppn),
            .s0_asid   (s0_asid),
            .s1_vppn   (s1_vppn),
            .s1_asid   (s1_asid),
            .entry     (slot_entries[g]),
            .hit0      (hit0_vec[g]),
            .hit1      (hit1_vec[g])
        );
    end

    tlb_hit_select #(
        .ENTRIES (ENTRIES)
    ) u_hit_select (
        .hit0_vec     (hit0_vec),
        .hit1_vec     (hit1_vec),
        .slot_entries (slot_entries),
        .s0_vppn      (s0_vppn),
        .s0_va_bit12  (s0_va_bit12),
        .s1_vppn      (s1_vppn),
        .s1_va_bit12  (s1_va_bit12),
        .s0_result    (s0_result),
        .s1_result    (s1_result)
    );

endmodule

/* src/tlb_hit_select.sv */
`timescale 1ns/10ps

module tlb_hit_select
    import tlb_pkg::*;
#(
    parameter int ENTRIES = 16
) (
    input  logic [ENTRIES-1:0] hit0_vec,
    input  logic [ENTRIES-1:0] hit1_vec,
    input  tlb_entry_t         slot_entries [ENTRIES],
    input  vppn_u              s0_vppn,
    input  logic               s0_va_bit12,
    input  vppn_u              s1_vppn,
    input  logic               s1_va_bit12,
    output tlb_result_t        s0_result,
    output tlb_result_t        s1_result
);

    function automatic tlb_result_t lookup(input logic [ENTRIES-1:0] hits,
                                           input vppn_u vppn,
                                           input logic va_bit12);
        tlb_result_t r;
        tlb_entry_t  ent;
        logic        odd;
        int          i;
        r = '0;
        // scan downward so the lowest index is the last one kept
        for (i = ENTRIES - 1; i >= 0; i--) begin
            if (hits[i]) begin
                ent = slot_entries[i];
                // top bit of the low half picks the page of a 4 MB pair
                odd = ent.ps4mb ? vppn.huge.lo[9] : va_bit12;
                r.found = 1'b1;
                r.index = 8'(i);
                r.ps = ent.ps4mb ? PS_4MB : PS_4KB;
                r.page = odd ? ent.page1 : ent.page0;
            end
        end
        return r;
    endfunction

    always_comb begin
        s0_result = lookup(hit0_vec, s0_vppn, s0_va_bit12);
    end

    always_comb begin
        s1_result = lookup(hit1_vec, s1_vppn, s1_va_bit12);
    end

endmodule

/* src/tlb_slot.sv */
`timescale 1ns/10ps

module tlb_slot
    import tlb_pkg::*, tlb_csr_pkg::*;
#(
    parameter int  ENTRIES = 16,
    parameter int  SLOT_ID = 0,
    localparam int IDX_W   = (ENTRIES > 1) ? $clog2(ENTRIES) : 1
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              wr_valid,
    input  logic [IDX_W-1:0]  wr_index,
    input  tlb_entry_t        wr_entry,
    input  logic              inv_valid,
    input  logic [4:0]        inv_op,
    input  logic [9:0]        inv_asid,
    input  vppn_u             inv_vppn,
    input  vppn_u             s0_vppn,
    input  logic [9:0]        s0_asid,
    input  vppn_u             s1_vppn,
    input  logic [9:0]        s1_asid,
    output tlb_entry_t        entry,
    output logic              hit0,
    output logic              hit1
);

    tlb_entry_t ent;
    logic       inv_asid_eq;
    logic       inv_vppn_eq;
    logic       inv_rule;
    logic       inv_hit;

    // 4 MB pages compare only the upper 9 bits
    function automatic logic vppn_match(input vppn_u stored, input logic ps4mb,
                                        input vppn_u va);
        if (ps4mb) begin
            return stored.huge.hi == va.huge.hi;
        end
        return stored.full == va.full;
    endfunction

    assign hit0 = ent.e && vppn_match(ent.vppn, ent.ps4mb, s0_vppn) &&
                  (ent.g || (ent.asid == s0_asid));
    assign hit1 = ent.e && vppn_match(ent.vppn, ent.ps4mb, s1_vppn) &&
                  (ent.g || (ent.asid == s1_asid));

    assign inv_asid_eq = ent.asid == inv_asid;
    assign inv_vppn_eq = vppn_match(ent.vppn, ent.ps4mb, inv_vppn);

    always_comb begin
        case (inv_op)
            INV_ALL0, INV_ALL1: inv_rule = 1'b1;
            INV_G1:             inv_rule = ent.g;
            INV_G0:             inv_rule = !ent.g;
            INV_G0_ASID:        inv_rule = !ent.g && inv_asid_eq;
            INV_G0_ASID_VPN:    inv_rule = !ent.g && inv_asid_eq && inv_vppn_eq;
            INV_G1_ASID_VPN:    inv_rule = ent.g && inv_asid_eq && inv_vppn_eq;
            default:            inv_rule = 1'b0;
        endcase
    end

    // only enabled entries are cleared
    assign inv_hit = inv_valid && ent.e && inv_rule;

    always_ff @(posedge clk) begin
        if (resetn) begin
            ent <= '0;
        end else if (inv_hit) begin
            ent <= '0;
        end else if (wr_valid && (wr_index == IDX_W'(SLOT_ID))) begin
            ent <= wr_entry;
        end
    end

    assign entry = ent;

endmodule

/* src/tlb_mgmt_wb.sv */
`timescale 1ns/10ps

module tlb_mgmt_wb
    import tlb_pkg::*, tlb_csr_pkg::*;
#(
    parameter int  ENTRIES = 16,
    localparam int IDX_W   = (ENTRIES > 1) ? $clog2(ENTRIES) : 1
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  logic [2:0]        adr,
    input  logic [31:0]       dat_w,
    input  tlb_entry_t        slot_entries [ENTRIES],
    output logic [31:0]       dat_r,
    output logic              ack,
    output logic              wr_valid,
    output logic [IDX_W-1:0]  wr_index,
    output tlb_entry_t        wr_entry,
    output logic              inv_valid,
    output logic [4:0]        inv_op,
    output logic [9:0]        inv_asid,
    output vppn_u             inv_vppn
);

    tlb_entry_t       stg;
    logic [IDX_W-1:0] stg_index;
    logic             rd_pend;
    logic             req;
    logic             cmd_wr;

    // LO word layout: v, d, plv, mat, ppn
    function automatic logic [31:0] lo_word(input tlb_page_t p);
        logic [31:0] w;
        w = '0;
        w[0] = p.v;
        w[1] = p.d;
        w[3:2] = p.plv;
        w[5:4] = p.mat;
        w[LO_PPN_LSB +: 20] = p.ppn;
        return w;
    endfunction

    function automatic tlb_page_t lo_page(input logic [31:0] w);
        tlb_page_t p;
        p.v = w[0];
        p.d = w[1];
        p.plv = w[3:2];
        p.mat = w[5:4];
        p.ppn = w[LO_PPN_LSB +: 20];
        return p;
    endfunction

    // no new request while ack is up
    assign req = cyc && stb && !ack;
    assign cmd_wr = req && we && (adr == REG_CMD);

    always_ff @(posedge clk) begin
        if (resetn) begin
            ack <= 1'b0;
            wr_valid <= 1'b0;
            inv_valid <= 1'b0;
            rd_pend <= 1'b0;
            inv_op <= '0;
            stg <= '0;
            stg_index <= '0;
        end else begin
            ack <= req;
            wr_valid <= cmd_wr && (dat_w[1:0] == CMD_WRITE);
            inv_valid <= cmd_wr && (dat_w[1:0] == CMD_INV);
            rd_pend <= cmd_wr && (dat_w[1:0] == CMD_READ);
            if (cmd_wr) begin
                inv_op <= dat_w[CMD_INV_OP_LSB +: 5];
            end
            if (rd_pend) begin
                // read-back lands in the staging registers
                stg <= slot_entries[stg_index];
            end else if (req && we) begin
                case (adr)
                    REG_HI: begin
                        stg.vppn.full <= dat_w[HI_VPPN_LSB +: 19];
                        stg.e <= dat_w[0];
                        stg.ps4mb <= dat_w[1];
                        stg.g <= dat_w[2];
                    end
                    REG_ASID:  stg.asid <= dat_w[9:0];
                    REG_LO0:   stg.page0 <= lo_page(dat_w);
                    REG_LO1:   stg.page1 <= lo_page(dat_w);
                    REG_INDEX: stg_index <= dat_w[IDX_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        dat_r = '0;
        case (adr)
            REG_HI: begin
                dat_r[HI_VPPN_LSB +: 19] = stg.vppn.full;
                dat_r[2:0] = {stg.g, stg.ps4mb, stg.e};
            end
            REG_ASID:  dat_r[9:0] = stg.asid;
            REG_LO0:   dat_r = lo_word(stg.page0);
            REG_LO1:   dat_r = lo_word(stg.page1);
            REG_INDEX: dat_r[IDX_W-1:0] = stg_index;
            default: ;
        endcase
    end

    assign wr_index = stg_index;
    assign wr_entry = stg;
    // invalidate compares against staged HI and ASID
    assign inv_asid = stg.asid;
    assign inv_vppn = stg.vppn;

endmodule

/* src/tlb_csr_pkg.sv */
package tlb_csr_pkg;

    // register word offsets
    localparam logic [2:0] REG_HI    = 3'd0;
    localparam logic [2:0] REG_ASID  = 3'd1;
    localparam logic [2:0] REG_LO0   = 3'd2;
    localparam logic [2:0] REG_LO1   = 3'd3;
    localparam logic [2:0] REG_INDEX = 3'd4;
    localparam logic [2:0] REG_CMD   = 3'd5;

    // field positions inside the register words
    localparam int HI_VPPN_LSB    = 13;
    localparam int LO_PPN_LSB     = 8;
    localparam int CMD_INV_OP_LSB = 4;

    // command codes in CMD bits 1:0
    localparam logic [1:0] CMD_WRITE = 2'd1;
    localparam logic [1:0] CMD_READ  = 2'd2;
    localparam logic [1:0] CMD_INV   = 2'd3;

    // invalidate opcodes
    localparam logic [4:0] INV_ALL0        = 5'd0;
    localparam logic [4:0] INV_ALL1        = 5'd1;
    localparam logic [4:0] INV_G1          = 5'd2;
    localparam logic [4:0] INV_G0          = 5'd3;
    localparam logic [4:0] INV_G0_ASID     = 5'd4;
    localparam logic [4:0] INV_G0_ASID_VPN = 5'd5;
    localparam logic [4:0] INV_G1_ASID_VPN = 5'd6;

endpackage

/* src/tlb_pkg.sv */
package tlb_pkg;

    // one vppn word, read whole for 4 KB pages or split for 4 MB pages
    typedef union packed {
        logic [18:0] full;
        struct packed {
            logic [8:0] hi;
            logic [9:0] lo;
        } huge;
    } vppn_u;

    // one half of a page pair
    typedef struct packed {
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
    } tlb_page_t;

    typedef struct packed {
        logic        e;
        logic        ps4mb;
        logic        g;
        logic [9:0]  asid;
        vppn_u       vppn;
        tlb_page_t   page0;
        tlb_page_t   page1;
    } tlb_entry_t;

    typedef struct packed {
        logic        found;
        logic [7:0]  index;
        logic [5:0]  ps;
        tlb_page_t   page;
    } tlb_result_t;

    localparam logic [5:0] PS_4KB = 6'd12;
    localparam logic [5:0] PS_4MB = 6'd22;

endpackage
